/* source/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

////////////////////////////////////////
// Datapath sizing.
////////////////////////////////////////

// Register width of the core.
`define XLEN 32

// One quotient bit per divider step.
`define DIV_STEPS `XLEN

`endif

/* source/rv_datapath_pkg.sv */
`include "rv_defines.svh"

package rv_datapath_pkg;

	// Operand and result word.
	typedef logic [`XLEN-1:0] data_t;

	// Multiplier operand with one extra sign or zero bit.
	typedef logic [`XLEN:0] ext_t;

	// Full product of two extended operands.
	typedef logic [2*`XLEN+1:0] prod_t;

	// Divider step index, one bit wider than needed for DIV_STEPS-1.
	typedef logic [$clog2(`DIV_STEPS):0] step_t;

	// Sequencing states of the unit.
	typedef enum logic [1:0] {
		IDLE,
		MUL_RUN,
		DIV_RUN,
		FINISH
	} mdu_state_t;

endpackage

/* source/rv_instr_pkg.sv */
package rv_instr_pkg;

	// Raw instruction word.
	typedef logic [31:0] instr_t;

	// Position of funct3 inside the word.
	localparam int FUNCT3_LSB = 12;
	localparam int FUNCT3_MSB = 14;

	////////////////////////////////////////
	// M-extension operations.
	////////////////////////////////////////

	// Bit 2 separates divides from multiplies.
	typedef enum logic [2:0] {
		MUL    = 3'd0,
		MULH   = 3'd1,
		MULHSU = 3'd2,
		MULHU  = 3'd3,
		DIV    = 3'd4,
		DIVU   = 3'd5,
		REM    = 3'd6,
		REMU   = 3'd7
	} funct3_t;

endpackage

/* source/mdu_control.sv */
module mdu_control (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic is_div,
	input  logic last_step,
	output logic busy,
	output logic done,
	output logic load,
	output logic mul_en,
	output logic div_load,
	output logic div_step,
	output logic cnt_clear
);

import rv_datapath_pkg::*;

mdu_state_t state;
mdu_state_t state_next;

always_ff @(posedge clk) begin
	if (rst) begin
		state <= IDLE;
		done  <= 1'b0;
	end else begin
		state <= state_next;
		done  <= (state == FINISH);
	end
end

// Operands land at the start edge, so the first busy cycle picks the path.
always_comb begin : next_state
	state_next = state;
	unique case (state)
		IDLE:    if (start) state_next = MUL_RUN;
		MUL_RUN: state_next = is_div ? DIV_RUN : FINISH;
		DIV_RUN: if (last_step) state_next = FINISH;
		FINISH:  state_next = IDLE;
	endcase
end

assign busy      = (state != IDLE);
assign load      = start && (state == IDLE);
assign mul_en    = (state == MUL_RUN) && !is_div;
assign div_load  = (state == MUL_RUN) && is_div;
assign div_step  = (state == DIV_RUN);
assign cnt_clear = (state == MUL_RUN);

////////////////////////////////////////
// Checks.
////////////////////////////////////////

assert property (@(posedge clk) disable iff (rst) done |=> !done);

// The step count starts from zero on the first step.
assert property (@(posedge clk) disable iff (rst) $rose(div_step) |-> !last_step);

endmodule

/* source/mdu_step_counter.sv */
`include "rv_defines.svh"

module mdu_step_counter (
	input  logic clk,
	input  logic rst,
	input  logic clear,
	input  logic enable,
	output logic last_step
);

import rv_datapath_pkg::*;

localparam step_t LAST = step_t'(`DIV_STEPS - 1);

step_t count;

// Holds on the last step until the next clear.
always_ff @(posedge clk) begin
	if (rst || clear) begin
		count <= '0;
	end else if (enable && !last_step) begin
		count <= count + 1'b1;
	end
end

assign last_step = (count == LAST);

// No step follows the last one.
assert property (@(posedge clk) disable iff (rst) enable && last_step |=> !enable);

endmodule

/* source/mdu_operand_prep.sv */
`include "rv_defines.svh"

module mdu_operand_prep (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   load,
	input  rv_instr_pkg::funct3_t  funct3,
	input  rv_datapath_pkg::data_t a_in,
	input  rv_datapath_pkg::data_t b_in,
	output rv_instr_pkg::funct3_t  op,
	output rv_datapath_pkg::ext_t  mul_a,
	output rv_datapath_pkg::ext_t  mul_b,
	output rv_datapath_pkg::data_t div_num,
	output rv_datapath_pkg::data_t div_den,
	output logic                   num_neg,
	output logic                   den_neg,
	output rv_datapath_pkg::data_t a_reg,
	output rv_datapath_pkg::data_t b_reg
);

import rv_datapath_pkg::*;
import rv_instr_pkg::*;

logic signed_div;

always_ff @(posedge clk) begin
	if (rst) begin
		op <= MUL;
	end else if (load) begin
		op <= funct3;
	end
end

always_ff @(posedge clk) begin
	if (load) begin
		a_reg <= a_in;
		b_reg <= b_in;
	end
end

// MULHSU takes rs1 signed and rs2 unsigned.
always_comb begin : mul_ext
	unique case (op)
		MUL, MULH, MULHSU: mul_a = {a_reg[`XLEN-1], a_reg};
		MULHU:             mul_a = {1'b0, a_reg};
		default:           mul_a = '0;
	endcase
	unique case (op)
		MUL, MULH:     mul_b = {b_reg[`XLEN-1], b_reg};
		MULHSU, MULHU: mul_b = {1'b0, b_reg};
		default:       mul_b = '0;
	endcase
end

// Divider runs on magnitudes.
assign signed_div = (op == DIV) || (op == REM);
assign num_neg    = signed_div && a_reg[`XLEN-1];
assign den_neg    = signed_div && b_reg[`XLEN-1];
assign div_num    = num_neg ? -a_reg : a_reg;
assign div_den    = den_neg ? -b_reg : b_reg;

endmodule

/* source/mdu_multiplier.sv */
`include "rv_defines.svh"

module mdu_multiplier (
	input  logic                   clk,
	input  logic                   mul_en,
	input  rv_datapath_pkg::ext_t  mul_a,
	input  rv_datapath_pkg::ext_t  mul_b,
	output rv_datapath_pkg::prod_t product
);

import rv_datapath_pkg::*;

logic signed [2*`XLEN+1:0] product_s;

////////////////////////////////////////
// Signed 33x33 product.
////////////////////////////////////////

// Both operands are already extended, so a signed multiply covers all four ops.
always_comb begin : mul_core
	product_s = $signed(mul_a) * $signed(mul_b);
end

always_ff @(posedge clk) begin
	if (mul_en) begin
		product <= prod_t'(product_s);
	end
end

endmodule

/* source/mdu_divider.sv */
`include "rv_defines.svh"

module mdu_divider (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   div_load,
	input  logic                   div_step,
	input  rv_datapath_pkg::data_t div_num,
	input  rv_datapath_pkg::data_t div_den,
	output rv_datapath_pkg::data_t quotient,
	output rv_datapath_pkg::data_t remainder
);

import rv_datapath_pkg::*;

data_t       den_q;
logic [`XLEN:0] rem_shift;
logic [`XLEN:0] rem_diff;
logic        borrow;

// Dividend bits shift out of the quotient register into the remainder.
always_comb begin : trial_sub
	rem_shift = {remainder, quotient[`XLEN-1]};
	rem_diff  = rem_shift - {1'b0, den_q};
	borrow    = rem_diff[`XLEN];
end

always_ff @(posedge clk) begin
	if (div_load) begin
		den_q <= div_den;
	end
end

////////////////////////////////////////
// Restoring shift-subtract.
////////////////////////////////////////

always_ff @(posedge clk) begin
	if (rst) begin
		quotient  <= '0;
		remainder <= '0;
	end else if (div_load) begin
		quotient  <= div_num;
		remainder <= '0;
	end else if (div_step) begin
		// Keep the shifted value on a borrow.
		if (borrow) begin
			remainder <= rem_shift[`XLEN-1:0];
			quotient  <= {quotient[`XLEN-2:0], 1'b0};
		end else begin
			remainder <= rem_diff[`XLEN-1:0];
			quotient  <= {quotient[`XLEN-2:0], 1'b1};
		end
	end
end

endmodule

/* source/mdu_result_select.sv */
`include "rv_defines.svh"

module mdu_result_select (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   done,
	input  rv_instr_pkg::funct3_t  op,
	input  rv_datapath_pkg::prod_t product,
	input  rv_datapath_pkg::data_t quotient,
	input  rv_datapath_pkg::data_t remainder,
	input  rv_datapath_pkg::data_t a_reg,
	input  rv_datapath_pkg::data_t b_reg,
	input  logic                   num_neg,
	input  logic                   den_neg,
	output rv_datapath_pkg::data_t c_out
);

import rv_datapath_pkg::*;
import rv_instr_pkg::*;

localparam data_t MOST_NEG = {1'b1, {(`XLEN-1){1'b0}}};

data_t quot_signed;
data_t rem_signed;
data_t result;
logic  div_by_zero;
logic  overflow;

// Remainder takes the sign of the dividend.
assign quot_signed = (num_neg ^ den_neg) ? -quotient : quotient;
assign rem_signed  = num_neg ? -remainder : remainder;
assign div_by_zero = (b_reg == '0);
assign overflow    = (a_reg == MOST_NEG) && (b_reg == '1);

// Special cases per the RISC-V M chapter.
always_comb begin : result_sel
	unique case (op)
		MUL:                result = product[`XLEN-1:0];
		MULH, MULHSU, MULHU: result = product[2*`XLEN-1:`XLEN];
		DIV:    result = div_by_zero ? '1 : (overflow ? MOST_NEG : quot_signed);
		DIVU:   result = div_by_zero ? '1 : quotient;
		REM:    result = div_by_zero ? a_reg : (overflow ? '0 : rem_signed);
		REMU:   result = div_by_zero ? a_reg : remainder;
	endcase
end

always_ff @(posedge clk) begin
	if (rst) begin
		c_out <= '0;
	end else if (done) begin
		c_out <= result;
	end
end

endmodule

/* source/mult_div.sv */
module mult_div (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  rv_instr_pkg::instr_t   instr,
	input  rv_datapath_pkg::data_t a_in,
	input  rv_datapath_pkg::data_t b_in,
	output logic                   busy,
	output logic                   done,
	output rv_datapath_pkg::data_t c_out
);

import rv_datapath_pkg::*;
import rv_instr_pkg::*;

funct3_t funct3;
funct3_t op;
ext_t    mul_a;
ext_t    mul_b;
prod_t   product;
data_t   div_num;
data_t   div_den;
data_t   quotient;
data_t   remainder;
data_t   a_reg;
data_t   b_reg;
logic    num_neg;
logic    den_neg;
logic    load;
logic    mul_en;
logic    div_load;
logic    div_step;
logic    cnt_clear;
logic    last_step;
logic    finish;

assign funct3 = funct3_t'(instr[FUNCT3_MSB:FUNCT3_LSB]);

// Busy with no work strobe is the FINISH cycle, one edge ahead of done.
assign finish = busy && !(mul_en || div_load || div_step);

////////////////////////////////////////
// Sequencing.
////////////////////////////////////////

mdu_control control_i (
	.clk(clk), .rst(rst), .start(start), .is_div(op[2]), .last_step(last_step),
	.busy(busy), .done(done), .load(load), .mul_en(mul_en), .div_load(div_load),
	.div_step(div_step), .cnt_clear(cnt_clear)
);

mdu_step_counter step_counter_i (
	.clk(clk), .rst(rst), .clear(cnt_clear), .enable(div_step), .last_step(last_step)
);

////////////////////////////////////////
// Datapath.
////////////////////////////////////////

mdu_operand_prep operand_prep_i (
	.clk(clk), .rst(rst), .load(load), .funct3(funct3), .a_in(a_in), .b_in(b_in),
	.op(op), .mul_a(mul_a), .mul_b(mul_b), .div_num(div_num), .div_den(div_den),
	.num_neg(num_neg), .den_neg(den_neg), .a_reg(a_reg), .b_reg(b_reg)
);

mdu_multiplier multiplier_i (
	.clk(clk), .mul_en(mul_en), .mul_a(mul_a), .mul_b(mul_b), .product(product)
);

mdu_divider divider_i (
	.clk(clk), .rst(rst), .div_load(div_load), .div_step(div_step),
	.div_num(div_num), .div_den(div_den), .quotient(quotient), .remainder(remainder)
);

mdu_result_select result_select_i (
	.clk(clk), .rst(rst), .done(finish), .op(op), .product(product),
	.quotient(quotient), .remainder(remainder), .a_reg(a_reg), .b_reg(b_reg),
	.num_neg(num_neg), .den_neg(den_neg), .c_out(c_out)
);

endmodule

/* verification/mult_div_tb.sv */
module mult_div_tb;

timeunit 1ns;
timeprecision 100ps;

import rv_datapath_pkg::*;
import rv_instr_pkg::*;

localparam int TIMEOUT_CYCLES = 100;
localparam int MUL_LATENCY = 2;
localparam int DIV_LATENCY = 34;
localparam int RANDOM_OPS = 200;

logic   clk;
logic   rst;
logic   start;
instr_t instr;
data_t  a_in;
data_t  b_in;
logic   busy;
logic   done;
data_t  c_out;

integer seed;
int     errors;
int     checks;
int     tests_run;
int     errors_at_test_start;
string  test_name;

mult_div dut_i (
	.clk(clk), .rst(rst), .start(start), .instr(instr), .a_in(a_in), .b_in(b_in),
	.busy(busy), .done(done), .c_out(c_out)
);

always #10 clk = ~clk;

////////////////////////////////////////
// Reference model and helpers.
////////////////////////////////////////

// R-type OP word with funct7 = 1 selects the M extension.
function automatic instr_t make_instr(input funct3_t f3);
	return {7'b0000001, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
endfunction

function automatic int expected_latency(input funct3_t f3);
	return (f3 inside {DIV, DIVU, REM, REMU}) ? DIV_LATENCY : MUL_LATENCY;
endfunction

function automatic data_t model(input funct3_t f3, input data_t a, input data_t b);
	longint      sa;
	longint      sb;
	logic [63:0] ua;
	logic [63:0] ub;
	logic [63:0] full;
	logic        ovf;
	data_t       res;
	sa   = longint'($signed(a));
	sb   = longint'($signed(b));
	ua   = {32'd0, a};
	ub   = {32'd0, b};
	ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
	full = '0;
	case (f3)
		MUL, MULH: full = sa * sb;
		MULHSU:    full = sa * $signed(ub);
		MULHU:     full = ua * ub;
		default:   full = '0;
	endcase
	case (f3)
		MUL:     res = full[31:0];
		MULH, MULHSU, MULHU: res = full[63:32];
		DIV:     res = (b == '0) ? 32'hffff_ffff : (ovf ? 32'h8000_0000 : data_t'(sa / sb));
		DIVU:    res = (b == '0) ? 32'hffff_ffff : data_t'(ua / ub);
		REM:     res = (b == '0) ? a : (ovf ? 32'h0 : data_t'(sa % sb));
		REMU:    res = (b == '0) ? a : data_t'(ua % ub);
		default: res = '0;
	endcase
	return res;
endfunction

task automatic check_data(input string name, input data_t got, input data_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
	end
endtask

task automatic check_latency(input string name, input int got, input int exp);
	checks++;
	if (got != exp) begin
		errors++;
		$display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
	end
endtask

task automatic begin_test(input string name);
	test_name = name;
	errors_at_test_start = errors;
	tests_run++;
endtask

task automatic end_test();
	$display("Test %s finished with %0d error(s)", test_name, errors - errors_at_test_start);
endtask

// Inputs are scrambled after the start edge so only captured values count.
task automatic start_op(input funct3_t f3, input data_t a, input data_t b);
	@(negedge clk);
	start = 1'b1;
	instr = make_instr(f3);
	a_in  = a;
	b_in  = b;
	@(posedge clk);
	@(negedge clk);
	start = 1'b0;
	instr = make_instr(funct3_t'(~f3));
	a_in  = ~a;
	b_in  = ~b;
endtask

// Counts edges after the start edge until done is seen.
task automatic wait_done(output int edges, output bit ok);
	edges = 0;
	ok    = 1'b0;
	while (!ok && edges < TIMEOUT_CYCLES) begin
		@(posedge clk);
		edges++;
		@(negedge clk);
		if (done) begin
			ok = 1'b1;
		end else begin
			check_flag("busy", busy, 1'b1);
		end
	end
	if (!ok) begin
		errors++;
		$display("Timeout at %0t ns: done did not rise within %0d cycles", $time, edges);
	end
endtask

task automatic check_op(input funct3_t f3, input data_t a, input data_t b, input data_t exp);
	int edges;
	bit ok;
	start_op(f3, a, b);
	wait_done(edges, ok);
	if (ok) begin
		check_data($sformatf("c_out for %s %h %h", f3.name(), a, b), c_out, exp);
		check_latency("done latency", edges, expected_latency(f3));
	end
endtask

////////////////////////////////////////
// Directed tests.
////////////////////////////////////////

task automatic test_reset_state();
	begin_test("reset_state");
	check_flag("busy", busy, 1'b0);
	check_flag("done", done, 1'b0);
	check_data("c_out", c_out, '0);
	end_test();
endtask

task automatic test_mul_corners();
	data_t   corners [5] = '{32'h0000_0001, 32'hffff_ffff, 32'h8000_0000,
		32'h7fff_ffff, 32'h0000_0000};
	funct3_t ops [4] = '{MUL, MULH, MULHSU, MULHU};
	begin_test("mul_corners");
	foreach (ops[k]) begin
		foreach (corners[i]) begin
			foreach (corners[j]) begin
				check_op(ops[k], corners[i], corners[j],
					model(ops[k], corners[i], corners[j]));
			end
		end
	end
	end_test();
endtask

task automatic test_div_signs();
	data_t   a_vals [8] = '{32'd7, 32'hffff_fff9, 32'd7, 32'hffff_fff9,
		32'd100, 32'h8000_0001, 32'h7fff_ffff, 32'd3};
	data_t   b_vals [8] = '{32'd2, 32'd2, 32'hffff_fffe, 32'hffff_fffe,
		32'd7, 32'd3, 32'hffff_fffe, 32'd5};
	funct3_t ops [4] = '{DIV, DIVU, REM, REMU};
	begin_test("div_signs");
	foreach (ops[k]) begin
		foreach (a_vals[i]) begin
			check_op(ops[k], a_vals[i], b_vals[i], model(ops[k], a_vals[i], b_vals[i]));
		end
	end
	end_test();
endtask

task automatic test_div_zero();
	data_t a_vals [5] = '{32'd0, 32'd5, 32'h8000_0000, 32'hffff_ffff, 32'd12345};
	begin_test("div_zero");
	foreach (a_vals[i]) begin
		check_op(DIV, a_vals[i], '0, 32'hffff_ffff);
		check_op(DIVU, a_vals[i], '0, 32'hffff_ffff);
		check_op(REM, a_vals[i], '0, a_vals[i]);
		check_op(REMU, a_vals[i], '0, a_vals[i]);
	end
	end_test();
endtask

task automatic test_overflow();
	begin_test("overflow");
	check_op(DIV, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
	check_op(REM, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
	end_test();
endtask

// Second start lands five edges into a divide.
task automatic test_start_while_busy();
	int    edges;
	bit    ok;
	int    extra_dones;
	data_t exp;
	begin_test("start_while_busy");
	exp = model(DIV, 32'd1000, 32'd7);
	extra_dones = 0;
	start_op(DIV, 32'd1000, 32'd7);
	repeat (4) @(negedge clk);
	check_flag("busy", busy, 1'b1);
	start = 1'b1;
	instr = make_instr(MUL);
	a_in  = 32'd3;
	b_in  = 32'd5;
	@(negedge clk);
	start = 1'b0;
	wait_done(edges, ok);
	if (ok) begin
		check_data("c_out", c_out, exp);
		check_latency("done latency", edges + 5, DIV_LATENCY);
		repeat (DIV_LATENCY + 10) begin
			@(negedge clk);
			if (done) begin
				extra_dones++;
			end
		end
		checks++;
		if (extra_dones != 0) begin
			errors++;
			$display("A start while busy produced %0d extra done pulse(s)", extra_dones);
		end
		check_data("c_out held", c_out, exp);
		check_flag("busy", busy, 1'b0);
	end
	end_test();
endtask

task automatic test_random();
	integer  rnd;
	funct3_t f3;
	data_t   a;
	data_t   b;
	begin_test("random");
	for (int i = 0; i < RANDOM_OPS; i++) begin
		rnd = $random(seed);
		f3  = funct3_t'(rnd[2:0]);
		a   = $random(seed);
		b   = $random(seed);
		if (i % 25 == 0) begin
			b = '0;
		end
		check_op(f3, a, b, model(f3, a, b));
	end
	end_test();
endtask

initial begin : main
	seed      = 32'hd68ad7e7;
	errors    = 0;
	checks    = 0;
	tests_run = 0;
	clk   = 1'b0;
	rst   = 1'b1;
	start = 1'b0;
	instr = '0;
	a_in  = '0;
	b_in  = '0;
	repeat (10) @(posedge clk);
	@(negedge clk);
	rst = 1'b0;

	test_reset_state();
	test_mul_corners();
	test_div_signs();
	test_div_zero();
	test_overflow();
	test_start_while_busy();
	test_random();

	$display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
	if (errors == 0) begin
		$display("ALL TESTS PASSED");
	end else begin
		$display("SOME TESTS FAILED");
	end
	$finish;
end

endmodule

/* mult_div.f */
+incdir+source
source/rv_datapath_pkg.sv
source/rv_instr_pkg.sv
source/mdu_control.sv
source/mdu_step_counter.sv
source/mdu_operand_prep.sv
source/mdu_multiplier.sv
source/mdu_divider.sv
source/mdu_result_select.sv
source/mult_div.sv
verification/mult_div_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mult_div testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module mult_div_tb -f mult_div.f -o mult_div_sim
if [ $? -ne 0 ]; then
	echo "Verilator build did not complete"
	exit 1
fi

./obj_dir/mult_div_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL TESTS PASSED" "$LOG"; then
	exit 0
fi
echo "Simulation reported errors, see $LOG"
exit 1
